// ==== mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// address width of a cache request
`define ADDR_BITS 64

// one system bus word
`define BEAT_BITS 64

// one cache block
`define BLOCK_BITS 512

// bus beats per block
`define BEATS 8

// bus tag, write flag on top of the transaction number
`define TAG_BITS 13

`endif

// ==== bus_pkg.sv ====
`include "mem_settings.svh"

package bus_pkg;

  // one word on the system bus, address or data
  typedef logic [`BEAT_BITS-1:0] beat_t;

  // tag sent with the address beat and echoed on every response beat
  typedef struct packed {
    logic                 write;
    logic [`TAG_BITS-2:0] txn_id;
  } bus_tag_t;

endpackage

// ==== mem_pkg.sv ====
`include "mem_settings.svh"

package mem_pkg;

  // beat 0 sits in the least significant word
  typedef logic [`BLOCK_BITS-1:0] block_t;

  // block request as issued by a cache
  typedef struct packed {
    logic [`ADDR_BITS-1:0] address;
    logic                  write;
    block_t                wdata;
  } cache_req_t;

  typedef enum logic {
    icache,
    dcache
  } requester_t;

endpackage

// ==== cache_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module cache_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  icache_req,
  input  logic [`ADDR_BITS-1:0] icache_address,
  input  logic                  dcache_req,
  input  mem_pkg::cache_req_t   dcache_cmd,
  output logic                  icache_operation_complete,
  output logic                  dcache_operation_complete,
  output mem_pkg::block_t       icache_data,
  output mem_pkg::block_t       dcache_data,
  output logic                  mem_start,
  output mem_pkg::cache_req_t   mem_cmd,
  input  logic                  mem_done,
  input  mem_pkg::block_t       mem_block
);

  typedef enum logic [1:0] {
    arb_idle,
    arb_busy,
    arb_complete
  } arb_state_t;

  arb_state_t          state;
  mem_pkg::requester_t last_served;
  mem_pkg::requester_t grant;
  logic                pending;

  // on a tie the cache that was not served last goes first
  always_comb begin
    pending = icache_req | dcache_req;
    if (icache_req && dcache_req) begin
      grant = (last_served == mem_pkg::icache) ? mem_pkg::dcache : mem_pkg::icache;
    end else if (dcache_req) begin
      grant = mem_pkg::dcache;
    end else begin
      grant = mem_pkg::icache;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state                     <= arb_idle;
      // so the dcache takes the first tie
      last_served               <= mem_pkg::icache;
      mem_start                 <= 1'b0;
      icache_operation_complete <= 1'b0;
      dcache_operation_complete <= 1'b0;
    end else begin
      mem_start                 <= 1'b0;
      icache_operation_complete <= 1'b0;
      dcache_operation_complete <= 1'b0;
      case (state)
        arb_idle: begin
          if (pending) begin
            state       <= arb_busy;
            last_served <= grant;
            mem_start   <= 1'b1;
          end
        end
        arb_busy: begin
          if (mem_done) begin
            state                     <= arb_complete;
            icache_operation_complete <= (last_served == mem_pkg::icache);
            dcache_operation_complete <= (last_served == mem_pkg::dcache);
          end
        end
        // the owner still holds its request during the pulse, skip one cycle
        default: begin
          state <= arb_idle;
        end
      endcase
    end
  end

  // command is held until done, block goes to the owner only
  always_ff @(posedge clk) begin
    if (state == arb_idle && pending) begin
      if (grant == mem_pkg::dcache) begin
        mem_cmd <= dcache_cmd;
      end else begin
        mem_cmd <= '{address: icache_address, write: 1'b0, wdata: '0};
      end
    end
    if (state == arb_busy && mem_done) begin
      if (last_served == mem_pkg::icache) begin
        icache_data <= mem_block;
      end else begin
        dcache_data <= mem_block;
      end
    end
  end

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module line_buffer (
  input  logic            clk,
  input  logic            reset,
  input  logic            load,
  input  mem_pkg::block_t load_block,
  input  logic            shift_out,
  input  logic            shift_in,
  input  bus_pkg::beat_t  in_beat,
  output bus_pkg::beat_t  out_beat,
  output mem_pkg::block_t block
);

  mem_pkg::block_t data;

  always_ff @(posedge clk) begin
    if (reset) begin
      data <= '0;
    end else if (load) begin
      data <= load_block;
    end else if (shift_out) begin
      // next write beat drops into the low word
      data <= {{`BEAT_BITS{1'b0}}, data[`BLOCK_BITS-1:`BEAT_BITS]};
    end else if (shift_in) begin
      // beat enters at the top, beat 0 reaches the bottom after the last one
      data <= {in_beat, data[`BLOCK_BITS-1:`BEAT_BITS]};
    end
  end

  assign out_beat = data[`BEAT_BITS-1:0];
  assign block    = data;

endmodule

// ==== bus_controller.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module bus_controller (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  mem_pkg::cache_req_t cmd,
  output logic                done,
  output logic                buf_load,
  output mem_pkg::block_t     buf_load_block,
  output logic                buf_shift_out,
  output logic                buf_shift_in,
  output bus_pkg::beat_t      buf_in_beat,
  input  bus_pkg::beat_t      buf_out_beat,
  output logic                bus_reqcyc,
  output bus_pkg::beat_t      bus_req,
  output bus_pkg::bus_tag_t   bus_reqtag,
  input  logic                bus_reqack,
  input  logic                bus_respcyc,
  input  bus_pkg::beat_t      bus_resp,
  input  bus_pkg::bus_tag_t   bus_resptag,
  output logic                bus_respack
);

  localparam int cnt_bits = $clog2(`BEATS);
  localparam logic [cnt_bits-1:0] last_beat = cnt_bits'(`BEATS - 1);

  typedef enum logic [2:0] {
    ctl_idle,
    ctl_addr,
    ctl_wbeat,
    ctl_rbeat,
    ctl_finish
  } ctl_state_t;

  ctl_state_t           state;
  logic [cnt_bits-1:0]  beat_cnt;
  logic [`TAG_BITS-2:0] txn_count;

  assign done = (state == ctl_finish);

  // whole write block goes into the buffer with the start pulse
  assign buf_load       = (state == ctl_idle) && start && cmd.write;
  assign buf_load_block = cmd.wdata;

  // every acked beat of a write pulls the next data beat down
  assign buf_shift_out = bus_reqcyc && bus_reqack && bus_reqtag.write;

  // only beats tagged for the current read are taken
  assign bus_respack  = (state == ctl_rbeat) && bus_respcyc && (bus_resptag == bus_reqtag);
  assign buf_shift_in = bus_respack;
  assign buf_in_beat  = bus_resp;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ctl_idle;
      bus_reqcyc <= 1'b0;
      beat_cnt   <= '0;
      txn_count  <= '0;
    end else begin
      case (state)
        ctl_idle: begin
          if (start) begin
            state      <= ctl_addr;
            bus_reqcyc <= 1'b1;
          end
        end
        ctl_addr: begin
          if (bus_reqack) begin
            beat_cnt <= '0;
            if (bus_reqtag.write) begin
              state <= ctl_wbeat;
            end else begin
              state      <= ctl_rbeat;
              bus_reqcyc <= 1'b0;
            end
          end
        end
        ctl_wbeat: begin
          if (bus_reqack) begin
            if (beat_cnt == last_beat) begin
              state      <= ctl_finish;
              bus_reqcyc <= 1'b0;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        ctl_rbeat: begin
          // gaps between response beats just hold the count
          if (bus_respack) begin
            if (beat_cnt == last_beat) begin
              state <= ctl_finish;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        ctl_finish: begin
          state     <= ctl_idle;
          txn_count <= txn_count + 1'b1;
        end
        default: begin
          state <= ctl_idle;
        end
      endcase
    end
  end

  // address beat first, then each write beat once the previous one is acked
  always_ff @(posedge clk) begin
    if (state == ctl_idle && start) begin
      bus_req    <= cmd.address;
      bus_reqtag <= '{write: cmd.write, txn_id: txn_count};
    end else if (buf_shift_out) begin
      bus_req <= buf_out_beat;
    end
  end

endmodule

// ==== mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  icache_req,
  input  logic [`ADDR_BITS-1:0] icache_address,
  input  logic                  dcache_req,
  input  mem_pkg::cache_req_t   dcache_cmd,
  output logic                  icache_operation_complete,
  output logic                  dcache_operation_complete,
  output mem_pkg::block_t       icache_data,
  output mem_pkg::block_t       dcache_data,
  output logic                  bus_reqcyc,
  output bus_pkg::beat_t        bus_req,
  output bus_pkg::bus_tag_t     bus_reqtag,
  input  logic                  bus_reqack,
  input  logic                  bus_respcyc,
  input  bus_pkg::beat_t        bus_resp,
  input  bus_pkg::bus_tag_t     bus_resptag,
  output logic                  bus_respack
);

  // arbiter to controller
  logic                mem_start;
  logic                mem_done;
  mem_pkg::cache_req_t mem_cmd;

  // controller to block buffer
  logic                buf_load;
  mem_pkg::block_t     buf_load_block;
  logic                buf_shift_out;
  logic                buf_shift_in;
  bus_pkg::beat_t      buf_in_beat;
  bus_pkg::beat_t      buf_out_beat;
  mem_pkg::block_t     buf_block;

  cache_arbiter u_arbiter (
    .clk                       (clk),
    .reset                     (reset),
    .icache_req                (icache_req),
    .icache_address            (icache_address),
    .dcache_req                (dcache_req),
    .dcache_cmd                (dcache_cmd),
    .icache_operation_complete (icache_operation_complete),
    .dcache_operation_complete (dcache_operation_complete),
    .icache_data               (icache_data),
    .dcache_data               (dcache_data),
    .mem_start                 (mem_start),
    .mem_cmd                   (mem_cmd),
    .mem_done                  (mem_done),
    .mem_block                 (buf_block)
  );

  line_buffer u_line_buffer (
    .clk        (clk),
    .reset      (reset),
    .load       (buf_load),
    .load_block (buf_load_block),
    .shift_out  (buf_shift_out),
    .shift_in   (buf_shift_in),
    .in_beat    (buf_in_beat),
    .out_beat   (buf_out_beat),
    .block      (buf_block)
  );

  bus_controller u_bus_controller (
    .clk            (clk),
    .reset          (reset),
    .start          (mem_start),
    .cmd            (mem_cmd),
    .done           (mem_done),
    .buf_load       (buf_load),
    .buf_load_block (buf_load_block),
    .buf_shift_out  (buf_shift_out),
    .buf_shift_in   (buf_shift_in),
    .buf_in_beat    (buf_in_beat),
    .buf_out_beat   (buf_out_beat),
    .bus_reqcyc     (bus_reqcyc),
    .bus_req        (bus_req),
    .bus_reqtag     (bus_reqtag),
    .bus_reqack     (bus_reqack),
    .bus_respcyc    (bus_respcyc),
    .bus_resp       (bus_resp),
    .bus_resptag    (bus_resptag),
    .bus_respack    (bus_respack)
  );

endmodule

// ==== mem_subsystem_sva.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem_sva (
  input logic              clk,
  input logic              reset,
  input logic              bus_reqcyc,
  input logic              bus_reqack,
  input bus_pkg::beat_t    bus_req,
  input bus_pkg::bus_tag_t bus_reqtag,
  input logic              bus_respcyc,
  input bus_pkg::bus_tag_t bus_resptag,
  input logic              bus_respack,
  input logic              done
);

  // a beat that is not yet acknowledged stays on the bus unchanged
  req_held: assert property (@(posedge clk) disable iff (reset)
    (bus_reqcyc && !bus_reqack) |=> ($stable(bus_req) && $stable(bus_reqtag)))
    else $error("bus request changed before bus_reqack");

  // response acks only for a live beat of a read whose address beat is done
  resp_ack_valid: assert property (@(posedge clk) disable iff (reset)
    bus_respack |-> (bus_respcyc && !bus_reqcyc && !bus_reqtag.write))
    else $error("bus_respack outside the response phase of a read");

  done_in_reset: assert property (@(posedge clk)
    (reset && $past(reset)) |-> !done)
    else $error("done raised during reset");

endmodule

bind bus_controller mem_subsystem_sva sva_inst (
  .clk         (clk),
  .reset       (reset),
  .bus_reqcyc  (bus_reqcyc),
  .bus_reqack  (bus_reqack),
  .bus_req     (bus_req),
  .bus_reqtag  (bus_reqtag),
  .bus_respcyc (bus_respcyc),
  .bus_resptag (bus_resptag),
  .bus_respack (bus_respack),
  .done        (done)
);

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_subsystem;

  localparam int wait_limit = 500;

  logic                  clk;
  logic                  reset;
  logic                  icache_req;
  logic [`ADDR_BITS-1:0] icache_address;
  logic                  dcache_req;
  mem_pkg::cache_req_t   dcache_cmd;
  logic                  icache_operation_complete;
  logic                  dcache_operation_complete;
  mem_pkg::block_t       icache_data;
  mem_pkg::block_t       dcache_data;
  logic                  bus_reqcyc;
  bus_pkg::beat_t        bus_req;
  bus_pkg::bus_tag_t     bus_reqtag;
  logic                  bus_reqack;
  logic                  bus_respcyc;
  bus_pkg::beat_t        bus_resp;
  bus_pkg::bus_tag_t     bus_resptag;
  logic                  bus_respack;

  integer seed;
  logic   expect_write;
  logic [`TAG_BITS-2:0] expected_txn;

  // reference contents seen by the caches, and the memory behind the bus
  mem_pkg::block_t     ref_mem [logic [`ADDR_BITS-1:0]];
  mem_pkg::block_t     bus_mem [logic [`ADDR_BITS-1:0]];
  mem_pkg::requester_t done_order [$];

  mem_subsystem UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_block(input string name, input mem_pkg::block_t exp,
                             input mem_pkg::block_t act);
    if (exp !== act) begin
      stop_with_error($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_tag(input string name, input bus_pkg::bus_tag_t exp,
                           input bus_pkg::bus_tag_t act);
    if (exp !== act) begin
      stop_with_error($sformatf("Mismatch %s: expected write=%0d txn=%0d actual write=%0d txn=%0d",
                                name, exp.write, exp.txn_id, act.write, act.txn_id));
    end
  endtask

  task automatic check_beat(input string name, input bus_pkg::beat_t exp,
                            input bus_pkg::beat_t act);
    if (exp !== act) begin
      stop_with_error($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_requester(input string name, input mem_pkg::requester_t exp,
                                 input mem_pkg::requester_t act);
    if (exp !== act) begin
      stop_with_error($sformatf("Mismatch %s: expected %s actual %s",
                                name, exp.name(), act.name()));
    end
  endtask

  // untouched memory, every beat depends on the full address
  function automatic mem_pkg::block_t fill_block(input logic [`ADDR_BITS-1:0] addr);
    mem_pkg::block_t b;
    for (int i = 0; i < `BEATS; i++) begin
      b[i*`BEAT_BITS +: `BEAT_BITS] = ~addr ^ (64'(i) << 48);
    end
    return b;
  endfunction

  function automatic mem_pkg::block_t expected_block(input logic [`ADDR_BITS-1:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : fill_block(addr);
  endfunction

  function automatic mem_pkg::block_t random_block();
    mem_pkg::block_t b;
    for (int k = 0; k < `BLOCK_BITS / 32; k++) begin
      b[k*32 +: 32] = $random(seed);
    end
    return b;
  endfunction

  // sixteen blocks, block aligned
  function automatic logic [`ADDR_BITS-1:0] random_addr();
    return 64'({$random(seed)} % 16) << 6;
  endfunction

  task automatic wait_complete(input mem_pkg::requester_t who, input bit lone);
    int   cycles;
    logic mine;
    logic other;
    cycles = 0;
    mine   = 1'b0;
    while (!mine) begin
      @(posedge clk);
      #1;
      cycles++;
      mine  = (who == mem_pkg::icache) ? icache_operation_complete : dcache_operation_complete;
      other = (who == mem_pkg::icache) ? dcache_operation_complete : icache_operation_complete;
      if (lone && other) begin
        stop_with_error($sformatf("other complete pulse during a lone %s request", who.name()));
      end
      if (!mine && cycles == wait_limit) begin
        stop_with_error($sformatf("timeout waiting for %s operation_complete", who.name()));
      end
    end
    done_order.push_back(who);
  endtask

  task automatic run_icache_read(input logic [`ADDR_BITS-1:0] addr, input bit lone);
    icache_address = addr;
    icache_req     = 1'b1;
    wait_complete(mem_pkg::icache, lone);
    check_block("icache read", expected_block(addr), icache_data);
    // request drops in the cycle after the pulse
    @(posedge clk);
    #1;
    icache_req = 1'b0;
  endtask

  task automatic run_dcache(input logic [`ADDR_BITS-1:0] addr, input logic write,
                            input bit lone);
    mem_pkg::block_t data;
    data       = random_block();
    dcache_cmd = '{address: addr, write: write, wdata: data};
    dcache_req = 1'b1;
    wait_complete(mem_pkg::dcache, lone);
    if (write) begin
      ref_mem[addr] = data;
    end else begin
      check_block("dcache read", expected_block(addr), dcache_data);
    end
    @(posedge clk);
    #1;
    dcache_req = 1'b0;
  endtask

  // hold off the ack for 0 to 3 cycles, then ack one edge
  task automatic ack_beat();
    int delay;
    delay = {$random(seed)} % 4;
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
    bus_reqack = 1'b1;
    @(posedge clk);
    #1;
    bus_reqack = 1'b0;
  endtask

  // bus memory model
  initial begin : bus_memory
    bus_pkg::bus_tag_t     tag;
    logic [`ADDR_BITS-1:0] addr;
    mem_pkg::block_t       blk;
    int                    cycles;
    int                    gap;
    bus_reqack   = 1'b0;
    bus_respcyc  = 1'b0;
    bus_resp     = '0;
    bus_resptag  = '0;
    expected_txn = '0;
    cycles       = 0;
    while (reset !== 1'b0) begin
      if (cycles == wait_limit) begin
        stop_with_error("timeout waiting for reset release");
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    forever begin
      cycles = 0;
      while (!bus_reqcyc) begin
        if (cycles == wait_limit) begin
          stop_with_error("timeout waiting for an address beat on the bus");
        end
        @(posedge clk);
        #1;
        cycles++;
      end
      tag  = bus_reqtag;
      addr = bus_req;
      check_tag("address beat tag",
                bus_pkg::bus_tag_t'{write: expect_write, txn_id: expected_txn}, tag);
      expected_txn = expected_txn + 1'b1;
      ack_beat();
      if (tag.write) begin
        check_beat("write address", dcache_cmd.address, addr);
        for (int i = 0; i < `BEATS; i++) begin
          if (!bus_reqcyc) begin
            stop_with_error("bus_reqcyc dropped before all write beats were sent");
          end
          blk[i*`BEAT_BITS +: `BEAT_BITS] = bus_req;
          ack_beat();
        end
        check_block("write data beats", dcache_cmd.wdata, blk);
        bus_mem[addr] = blk;
      end else begin
        blk = bus_mem.exists(addr) ? bus_mem[addr] : fill_block(addr);
        for (int i = 0; i < `BEATS; i++) begin
          gap = {$random(seed)} % 3;
          repeat (gap) begin
            // a beat of another transaction fills the gap and must be ignored
            bus_respcyc = 1'b1;
            bus_resp    = ~blk[i*`BEAT_BITS +: `BEAT_BITS];
            bus_resptag = '{write: 1'b0, txn_id: tag.txn_id - 1'b1};
            #1;
            if (bus_respack) begin
              stop_with_error("response beat with a foreign tag was acknowledged");
            end
            @(posedge clk);
            #1;
          end
          bus_respcyc = 1'b1;
          bus_resp    = blk[i*`BEAT_BITS +: `BEAT_BITS];
          bus_resptag = tag;
          #1;
          if (!bus_respack) begin
            stop_with_error("read response beat was not acknowledged");
          end
          @(posedge clk);
          #1;
          bus_respcyc = 1'b0;
        end
      end
    end
  end

  initial begin : stimulus
    logic [`ADDR_BITS-1:0] addr_d;
    mem_pkg::requester_t   exp_who;
    int                    kind;
    int                    idle;
    seed           = 32'h7c855f6b;
    reset          = 1'b1;
    icache_req     = 1'b0;
    icache_address = '0;
    dcache_req     = 1'b0;
    dcache_cmd     = '0;
    expect_write   = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    if (bus_reqcyc || bus_respack || icache_operation_complete || dcache_operation_complete) begin
      stop_with_error("an output was high right after reset");
    end

    // both caches request back to back, completions must alternate from the dcache
    fork
      repeat (4) run_icache_read(random_addr(), 1'b0);
      repeat (4) run_dcache(random_addr(), 1'b0, 1'b0);
    join
    for (int i = 0; i < done_order.size(); i++) begin
      exp_who = (i % 2 == 0) ? mem_pkg::dcache : mem_pkg::icache;
      check_requester($sformatf("tie order %0d", i), exp_who, done_order[i]);
    end

    // one cache at a time, random mix
    repeat (40) begin
      kind   = {$random(seed)} % 3;
      addr_d = random_addr();
      idle   = {$random(seed)} % 3;
      repeat (idle) begin
        @(posedge clk);
        #1;
      end
      if (kind == 0) begin
        run_icache_read(addr_d, 1'b1);
      end else if (kind == 1) begin
        run_dcache(addr_d, 1'b0, 1'b1);
      end else begin
        expect_write = 1'b1;
        run_dcache(addr_d, 1'b1, 1'b1);
        expect_write = 1'b0;
        // read the new block back
        run_icache_read(addr_d, 1'b1);
      end
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
bus_pkg.sv
mem_pkg.sv
cache_arbiter.sv
line_buffer.sv
bus_controller.sv
mem_subsystem.sv
mem_subsystem_sva.sv
tb_mem_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mem_subsystem
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
